//--- build.f
+incdir+logic
logic/scc_bus_pkg.sv
logic/scc_chan_pkg.sv
logic/scc_reg_access.sv
logic/scc_channel.sv
logic/scc_irq_ctrl.sv
logic/scc_read_mux.sv
logic/scc_top.sv
dv/scc_tb.sv

//--- dv/scc_cases.txt
# columns: op rs reg data mask, hex. op t test, w write, r read, p dcd pin, i irq_n, g peek, e end
# rs 1/0 control a/b, 3/2 data a/b. r, g and i compare data under mask, i uses bit 0 only
t 0 0 01 00
w 1 c a5 00
w 0 d c3 00
r 1 c a5 ff
r 0 9 c3 ff
r 0 0 44 ff
t 0 0 02 00
w 3 0 96 00
w 2 0 69 00
r 3 0 96 ff
r 0 8 69 ff
w 1 f 00 00
p 1 0 01 00
r 1 0 4c ff
p 1 0 00 00
r 1 0 44 ff
r 1 1 07 ff
r 0 b f8 ff
t 0 0 03 00
w 1 e ff 00
w 1 a ff 00
w 0 e ff 00
w 1 9 80 00
g 1 e e3 ff
g 1 a 60 ff
g 0 e ff ff
r 1 f 00 ff
r 1 c a5 ff
w 0 9 c0 00
r 1 f f8 ff
g 1 e f0 ff
g 0 e f0 ff
g 1 a 00 ff
t 0 0 04 00
w 1 1 01 00
w 1 9 08 00
i 0 0 01 00
p 1 0 01 00
i 0 0 00 00
r 1 3 08 ff
p 1 0 00 00
r 1 0 4c ff
p 1 0 01 00
w 1 0 10 00
i 0 0 01 00
t 0 0 05 00
w 0 2 81 00
r 0 2 87 ff
w 0 1 01 00
p 0 0 01 00
i 0 0 00 00
r 0 2 83 ff
r 1 3 01 ff
w 0 9 18 00
r 0 6 c1 ff
w 0 0 10 00
i 0 0 01 00
r 0 2 e1 ff
w 0 9 10 00
p 0 0 00 00
i 0 0 01 00
r 0 2 c1 ff
e 0 0 00 00

//--- dv/scc_tb.sv
module scc_tb;

	logic             clk;
	logic             reset_hw;
	logic             cep;
	logic             cen;
	logic             cs;
	logic             we;
	logic [1:0]       rs;
	logic [7:0]       wdata;
	logic [7:0]       rdata;
	logic             irq_n;
	logic             dcd_a;
	logic             dcd_b;
	logic             txd;
	logic             rts;
	logic             wreq;

	int               fd;
	int               code;
	int               n_cases = 0;	// operation lines in the case file.
	int               cycle_count = 0;
	int               cycle_limit = 50;
	int               test_id = 0;	// 0 until the first test line.
	int               test_errs = 0;
	int               tests_passed = 0;
	int               tests_failed = 0;
	int               error_count = 0;
	logic             running;
	logic [7:0]       op;	// one letter operation code.
	logic [7:0]       sel_f;	// rs column.
	logic [7:0]       reg_f;	// register index column.
	logic [7:0]       data_f;	// write data or expected value.
	logic [7:0]       mask_f;
	logic [8*128-1:0] rest;	// rest of a skipped line.

	scc_top uut (.clk, .cep, .cen, .reset_hw, .cs, .we, .rs, .wdata, .rdata, .irq_n,
		.rxd(1'b1), .cts(1'b1), .dcd_a, .dcd_b, .txd, .rts, .wreq);

	always #2 clk = ~clk;	// period 4.

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus helpers. entered and left 1 unit after a rising edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one cs cycle, then one idle cycle so the pointer moves over.
	task bus_access(input logic write, input logic [1:0] sel, input logic [7:0] val,
		input logic [7:0] mask);
		cs    = 1'b1;
		we    = write;
		rs    = sel;
		wdata = val;
		#2;	// rdata settled, edge still ahead.
		if (!write && ((rdata & mask) !== (val & mask))) begin
			$display("Mismatch rdata: got %h, expected %h", rdata & mask, val & mask);
			test_errs++;
		end
		@(posedge clk);
		#1;
		cs = 1'b0;
		we = 1'b0;
		@(posedge clk);
		#1;
	endtask

	// control registers other than 0 need the wr0 pointer first.
	task reg_access(input logic write, input logic [1:0] sel, input logic [3:0] idx,
		input logic [7:0] val, input logic [7:0] mask);
		if (!sel[1] && idx != 4'd0) begin
			bus_access(1'b1, sel, {2'b00, idx[3] ? 3'b001 : 3'b000, idx[2:0]}, 8'h00);
		end
		bus_access(write, sel, val, mask);
	endtask

	// serial pins stay at their idle level.
	task check_idle_pins;
		if (txd !== 1'b1) begin
			$display("Mismatch txd: got %h, expected %h", txd, 1'b1);
			test_errs++;
		end
		if (rts !== 1'b1) begin
			$display("Mismatch rts: got %h, expected %h", rts, 1'b1);
			test_errs++;
		end
		if (wreq !== 1'b1) begin
			$display("Mismatch wreq: got %h, expected %h", wreq, 1'b1);
			test_errs++;
		end
	endtask

	// write registers with no read path.
	function automatic logic [7:0] peek_reg(input logic side_a, input logic [3:0] idx);
		case (idx)
			4'd10:   peek_reg = side_a ? uut.chan_a.regs.wr10 : uut.chan_b.regs.wr10;
			4'd14:   peek_reg = side_a ? uut.chan_a.regs.wr14 : uut.chan_b.regs.wr14;
			default: peek_reg = side_a ? uut.chan_a.regs.wr1 : uut.chan_b.regs.wr1;
		endcase
	endfunction

	task close_test;
		if (test_id != 0) begin
			if (test_errs == 0) begin
				$display("test %0d passed", test_id);
				tests_passed++;
			end else begin
				$display("test %0d failed with %0d errors", test_id, test_errs);
				tests_failed++;
			end
		end
		error_count += test_errs;
		test_errs = 0;
	endtask

	task run_case;
		case (op)
			"t": begin
				close_test();
				test_id = int'(data_f);
			end
			"w": reg_access(1'b1, sel_f[1:0], reg_f[3:0], data_f, mask_f);
			"r": reg_access(1'b0, sel_f[1:0], reg_f[3:0], data_f, mask_f);
			"p": begin
				if (sel_f[0]) begin
					dcd_a = data_f[0];
				end else begin
					dcd_b = data_f[0];
				end
				@(posedge clk);	// latch steps on this cep edge.
				#1;
			end
			"i": begin
				#2;
				if (irq_n !== data_f[0]) begin
					$display("Mismatch irq_n: got %h, expected %h", irq_n, data_f[0]);
					test_errs++;
				end
				check_idle_pins();
				@(posedge clk);
				#1;
			end
			"g": begin
				if ((peek_reg(sel_f[0], reg_f[3:0]) & mask_f) !== (data_f & mask_f)) begin
					$display("Mismatch chan_%s.wr%0d: got %h, expected %h",
						sel_f[0] ? "a" : "b", reg_f, peek_reg(sel_f[0], reg_f[3:0]),
						data_f & mask_f);
					test_errs++;
				end
			end
			"e": running = 1'b0;
			default: begin
				$display("case file holds an unknown operation code %h", op);
				test_errs++;
			end
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence. count the cases, reset, play the file, report.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		clk      = 1'b0;
		reset_hw = 1'b1;
		cep      = 1'b1;	// both enables tied high.
		cen      = 1'b1;
		cs       = 1'b0;
		we       = 1'b0;
		rs       = 2'b00;
		wdata    = 8'h00;
		dcd_a    = 1'b0;
		dcd_b    = 1'b0;
		fd = $fopen("dv/scc_cases.txt", "r");
		while (fd != 0 && !$feof(fd)) begin
			code = $fscanf(fd, "%s", op);
			if (code == 1 && op != "#") begin
				n_cases++;
			end
			code = $fgets(rest, fd);
		end
		if (fd == 0) begin
			$display("could not open the case file dv/scc_cases.txt");
			$display("TB FAILED");
			$finish;
		end else begin
			$fclose(fd);
			fd = $fopen("dv/scc_cases.txt", "r");
			cycle_limit = 8 * n_cases + 50;
			repeat (4) @(posedge clk);
			#1;
			reset_hw = 1'b0;
			check_idle_pins();
			running  = 1'b1;
			while (running && !$feof(fd)) begin
				code = $fscanf(fd, "%s", op);
				if (code != 1) begin
					running = 1'b0;	// end of file.
				end else if (op == "#") begin
					code = $fgets(rest, fd);
				end else begin
					code = $fscanf(fd, "%h %h %h %h", sel_f, reg_f, data_f, mask_f);
					run_case();
				end
			end
			close_test();
			$fclose(fd);
			$display("%0d tests passed, %0d tests failed, %0d errors",
				tests_passed, tests_failed, error_count);
			if (error_count == 0) begin
				$display("TB PASSED");
			end else begin
				$display("TB FAILED");
			end
			$finish;
		end
	end

endmodule

//--- logic/scc_bus_pkg.sv
package scc_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// cpu side of the scc: pointer, control writes, reset commands.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// indirect register pointer, 16 slots.
	typedef logic [3:0] reg_index_t;

	// a control register write in this cycle.
	// at most one side bit is set, data is the raw cpu byte.
	typedef struct packed {
		logic       valid_a;	// side a control port.
		logic       valid_b;	// side b control port.
		reg_index_t index;	// active pointer at the time.
		logic [7:0] data;	// byte being written.
	} wr_strobe_t;

	// reset pulses decoded from wr9[7:6].
	// full is also high for the whole hardware reset.
	typedef struct packed {
		logic full;	// force hardware reset, or reset_hw.
		logic chan_a;	// channel a reset only.
		logic chan_b;	// channel b reset only.
	} reset_kind_t;

endpackage

//--- logic/scc_chan_pkg.sv
package scc_chan_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per channel state, as seen by the interrupt and read logic.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// write registers that something outside the channel reads.
	// wr5 stays inside the channel.
	typedef struct packed {
		logic [7:0] wr1;	// interrupt enables, bit 0 is ext/status.
		logic [7:0] wr10;	// misc tx/rx control.
		logic [7:0] wr12;	// baud constant low.
		logic [7:0] wr13;	// baud constant high.
		logic [7:0] wr14;	// misc control.
		logic [7:0] wr15;	// ext/status enables, bit 3 is dcd.
	} chan_regs_t;

	// status out of the dcd latch.
	typedef struct packed {
		logic dcd_shown;	// what rr0[3] reports.
		logic ext_pending;	// ext/status interrupt pending.
	} chan_stat_t;

endpackage

//--- logic/scc_channel.sv
`include "scc_params.svh"

module scc_channel (
	input  logic                     clk,
	input  logic                     reset_hw,
	input  logic                     cen,
	input  logic                     cep,
	input  logic                     side,	// 1 serves side a, 0 side b.
	input  scc_bus_pkg::wr_strobe_t  wr,
	input  logic                     full_reset,
	input  logic                     chan_reset,
	input  logic                     dcd,	// raw pin, not synchronized.
	output scc_chan_pkg::chan_regs_t regs,
	output scc_chan_pkg::chan_stat_t stat
);

	logic       sel;	// control write aimed at this channel.
	logic [7:0] wr5;	// tx params, only the reset rule reads it.
	logic [7:0] wr1_kept;	// wr1 after any reset, bits 5 and 2 survive.
	logic [7:0] wr5_kept;	// wr5 after any reset, bits 6:5 and 0 survive.

	logic       latch_open;	// latch tracks nothing until it closes.
	logic       dcd_latch;	// captured dcd level.
	logic       ext_pending;	// ext/status interrupt pending.
	logic       dcd_ip;	// enabled dcd change seen.
	logic       do_latch;	// close the latch this cep.
	logic       do_ext_reset;	// wr0 reset ext/status command.

	assign sel      = side ? wr.valid_a : wr.valid_b;
	assign wr1_kept = {2'b00, regs.wr1[5], 2'b00, regs.wr1[2], 2'b00};
	assign wr5_kept = {1'b0, wr5[6:5], 4'b0000, wr5[0]};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write registers. full reset first, then channel reset, then writes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			regs.wr1  <= '0;
			wr5       <= '0;
			regs.wr10 <= '0;
			regs.wr12 <= '0;
			regs.wr13 <= '0;
			regs.wr14 <= {2'b00, `SCC_WR14_FULL_LOW};
			regs.wr15 <= `SCC_WR15_RESET;
		end else if (cen) begin
			if (full_reset) begin
				regs.wr1  <= wr1_kept;
				wr5       <= wr5_kept;
				regs.wr10 <= '0;
				regs.wr14 <= {regs.wr14[7:6], `SCC_WR14_FULL_LOW};	// top bits survive.
				regs.wr15 <= `SCC_WR15_RESET;
			end else if (chan_reset) begin
				regs.wr1  <= wr1_kept;
				wr5       <= wr5_kept;
				regs.wr10 <= {1'b0, regs.wr10[6:5], 5'b00000};	// keeps 6:5.
				regs.wr14 <= {regs.wr14[7:6], `SCC_WR14_CHAN_MID, regs.wr14[1:0]};
			end else if (sel) begin
				case (wr.index)
					4'd1:    regs.wr1  <= wr.data;
					4'd5:    wr5       <= wr.data;
					4'd10:   regs.wr10 <= wr.data;
					4'd12:   regs.wr12 <= wr.data;	// untouched by resets.
					4'd13:   regs.wr13 <= wr.data;	// same.
					4'd14:   regs.wr14 <= wr.data;
					4'd15:   regs.wr15 <= wr.data;	// only a full reset clears it.
					default: ;	// shared or command registers.
				endcase
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// dcd latch and ext/status interrupt, stepped by cep.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign do_ext_reset = sel && wr.index == 4'd0 && wr.data[5:3] == `SCC_CMD_RESET_EXT;
	assign dcd_ip       = regs.wr15[3] && (dcd != dcd_latch);	// enabled and changed.
	assign do_latch     = latch_open && dcd_ip;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open  <= 1'b1;
			dcd_latch   <= 1'b0;
			ext_pending <= 1'b0;
		end else if (cen && full_reset) begin
			latch_open  <= 1'b1;	// software full reset.
			dcd_latch   <= 1'b0;
			ext_pending <= 1'b0;
		end else if (cep) begin
			if (do_ext_reset) begin
				latch_open  <= 1'b1;
				ext_pending <= 1'b0;
			end else if (do_latch) begin
				latch_open <= 1'b0;
				dcd_latch  <= dcd;
				if (regs.wr1[0]) begin
					ext_pending <= 1'b1;	// only with ext/status irq enabled.
				end
			end
		end
	end

	assign stat.dcd_shown   = regs.wr15[3] ? dcd_latch : dcd;	// latched or live.
	assign stat.ext_pending = ext_pending;

	a_pend_enabled: assert property (@(posedge clk) disable iff (reset_hw)
		$rose(ext_pending) |-> $past(regs.wr1[0]))
		else $error("ext/status pending set with wr1[0] clear");

endmodule

//--- logic/scc_irq_ctrl.sv
`include "scc_params.svh"

module scc_irq_ctrl (
	input  logic                     clk,
	input  logic                     reset_hw,
	input  logic                     cen,
	input  scc_bus_pkg::wr_strobe_t  wr,
	input  scc_chan_pkg::chan_stat_t stat_a,
	input  scc_chan_pkg::chan_stat_t stat_b,
	output logic [7:0]               wr2,	// interrupt vector.
	output logic [7:0]               rr2_b,	// vector with status mixed in.
	output logic [7:0]               rr3_a,	// pending bits, both channels.
	output logic [5:0]               wr9,	// master control, command bits dropped.
	output logic                     irq_n
);

	logic       ctl_write;	// either side, these are shared.
	logic       any_pending;
	logic [2:0] vec_stat;	// highest ranked source.

	assign ctl_write = wr.valid_a | wr.valid_b;

	// software resets leave both alone.
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			wr2 <= '0;
			wr9 <= '0;
		end else if (cen && ctl_write) begin
			if (wr.index == 4'd2) begin
				wr2 <= wr.data;
			end
			if (wr.index == `SCC_IDX_WR9) begin
				wr9 <= wr.data[5:0];	// 7:6 are reset commands.
			end
		end
	end

	// rx/tx sources are not modelled, their bits read 0.
	assign rr3_a = {4'b0000, stat_a.ext_pending, 2'b00, stat_b.ext_pending};

	assign any_pending = stat_a.ext_pending | stat_b.ext_pending;
	assign vec_stat    = stat_a.ext_pending ? 3'b101 :	// a ext/status.
	                     stat_b.ext_pending ? 3'b001 :	// b ext/status.
	                     `SCC_VEC_NONE;

	// wr9[4] picks status high (reversed in 6:4) or status low (3:1).
	assign rr2_b = wr9[4] ? {wr2[7], vec_stat[0], vec_stat[1], vec_stat[2], wr2[3:0]} :
	                        {wr2[7:4], vec_stat, wr2[0]};

	assign irq_n = ~(wr9[3] & any_pending);	// wr9[3] is master enable.

	a_mie_gates_irq: assert property (@(posedge clk) disable iff (reset_hw)
		!wr9[3] |-> irq_n)
		else $error("irq_n low with master interrupt enable clear");

endmodule

//--- logic/scc_params.svh
`ifndef SCC_PARAMS_SVH
`define SCC_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register indices reached through the wr0 pointer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SCC_IDX_WR9        4'd9         // master control, also carries reset commands.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// values forced by the reset rules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SCC_WR15_RESET     8'b1111_1000 // all ext/status enables set, dcd included.
`define SCC_WR14_FULL_LOW  6'b11_0000   // wr14[5:0] after a full reset.
`define SCC_WR14_CHAN_MID  4'b1000      // wr14[5:2] after a channel reset.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wr0 command field, bits 5:3.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SCC_CMD_POINT_HIGH 3'b001       // pointer gets +8.
`define SCC_CMD_RESET_EXT  3'b010       // clear ext/status pending, reopen latch.

`define SCC_VEC_NONE       3'b011       // vector status with nothing pending.

`endif

//--- logic/scc_read_mux.sv
module scc_read_mux (
	input  logic [1:0]               rs,
	input  scc_bus_pkg::reg_index_t  index,
	input  logic [7:0]               data_a,
	input  logic [7:0]               data_b,
	input  logic [7:0]               wr2,
	input  logic [7:0]               rr2_b,
	input  logic [7:0]               rr3_a,
	input  scc_chan_pkg::chan_regs_t regs_a,
	input  scc_chan_pkg::chan_regs_t regs_b,
	input  scc_chan_pkg::chan_stat_t stat_a,
	input  scc_chan_pkg::chan_stat_t stat_b,
	output logic [7:0]               rdata
);

	localparam logic [7:0] rr1_fixed  = 8'h07;	// all sent, residue 011.
	localparam logic [7:0] rr10_fixed = 8'h00;	// no loop, no missing clocks.

	logic       side_a;
	logic [7:0] rr0_a;
	logic [7:0] rr0_b;
	logic [7:0] rr15_a;
	logic [7:0] rr15_b;

	assign side_a = rs[0];

	// tx underrun and tx empty always up, dcd from the channel.
	assign rr0_a = {3'b010, 1'b0, stat_a.dcd_shown, 3'b100};
	assign rr0_b = {3'b010, 1'b0, stat_b.dcd_shown, 3'b100};

	// rr15 mirrors wr15 less the unimplemented bits.
	assign rr15_a = {regs_a.wr15[7:3], 1'b0, regs_a.wr15[1], 1'b0};
	assign rr15_b = {regs_b.wr15[7:3], 1'b0, regs_b.wr15[1], 1'b0};

	always_comb begin
		if (rs[1]) begin
			rdata = side_a ? data_a : data_b;	// data port.
		end else begin
			case (index)
				4'd0, 4'd4:   rdata = side_a ? rr0_a : rr0_b;
				4'd1, 4'd5:   rdata = rr1_fixed;
				4'd2, 4'd6:   rdata = side_a ? wr2 : rr2_b;	// a reads plain vector.
				4'd3, 4'd7:   rdata = side_a ? rr3_a : 8'h00;	// b has no rr3.
				4'd8:         rdata = side_a ? data_a : data_b;
				4'd9, 4'd13:  rdata = side_a ? regs_a.wr13 : regs_b.wr13;
				4'd10, 4'd14: rdata = rr10_fixed;
				4'd12:        rdata = side_a ? regs_a.wr12 : regs_b.wr12;
				default:      rdata = side_a ? rr15_a : rr15_b;	// 11 and 15.
			endcase
		end
	end

endmodule

//--- logic/scc_reg_access.sv
`include "scc_params.svh"

module scc_reg_access (
	input  logic                     clk,
	input  logic                     reset_hw,
	input  logic                     cen,
	input  logic                     cs,
	input  logic                     we,
	input  logic [1:0]               rs,	// [1] data/ctl, [0] side a/b.
	input  logic [7:0]               wdata,
	output scc_bus_pkg::reg_index_t  index,
	output scc_bus_pkg::wr_strobe_t  wr,
	output scc_bus_pkg::reset_kind_t resets,
	output logic [7:0]               data_a,
	output logic [7:0]               data_b
);

	scc_bus_pkg::reg_index_t pointer;	// pending pointer.
	logic                    ctl_write;	// control write on either side.
	logic                    wr9_write;	// that write lands in wr9.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write strobe and reset decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign wr.valid_a = cs & we & ~rs[1] & rs[0];	// side a ctl.
	assign wr.valid_b = cs & we & ~rs[1] & ~rs[0];	// side b ctl.
	assign wr.index   = index;
	assign wr.data    = wdata;

	assign ctl_write = wr.valid_a | wr.valid_b;
	assign wr9_write = ctl_write && (index == `SCC_IDX_WR9);	// shared, side ignored.

	assign resets.full   = reset_hw | (wr9_write && wdata[7:6] == 2'b11);
	assign resets.chan_a = wr9_write && wdata[7:6] == 2'b10;
	assign resets.chan_b = wr9_write && wdata[7:6] == 2'b01;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointer. wr0 loads it, any other ctl access drops it back to 0.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			pointer <= '0;
		end else if (cen && cs && !rs[1]) begin
			if (we && index == 4'd0) begin
				pointer <= {wdata[5:3] == `SCC_CMD_POINT_HIGH, wdata[2:0]};	// low bits + high.
			end else begin
				pointer <= '0;	// read or write of any other register.
			end
		end
	end

	// move over only between cpu cycles so rdata holds still.
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			index <= '0;
		end else if (!cs) begin
			index <= pointer;
		end
	end

	// data ports, no pointer involved.
	always_ff @(posedge clk) begin
		if (cen && cs && we && rs[1]) begin
			if (rs[0]) begin
				data_a <= wdata;
			end else begin
				data_b <= wdata;
			end
		end
	end

	a_one_side: assert property (@(posedge clk) disable iff (reset_hw)
		$onehot0({wr.valid_a, wr.valid_b}))
		else $error("control write strobed on both sides");

endmodule

//--- logic/scc_top.sv
module scc_top (
	input  logic       clk,
	input  logic       cep,
	input  logic       cen,
	input  logic       reset_hw,
	input  logic       cs,
	input  logic       we,
	input  logic [1:0] rs,	// [1] data/ctl, [0] side a/b.
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       irq_n,
	input  logic       rxd,	// shifters not modelled.
	input  logic       cts,
	input  logic       dcd_a,
	input  logic       dcd_b,
	output logic       txd,
	output logic       rts,
	output logic       wreq
);

	scc_bus_pkg::reg_index_t  index;
	scc_bus_pkg::wr_strobe_t  wr;
	scc_bus_pkg::reset_kind_t resets;
	scc_chan_pkg::chan_regs_t regs_a;
	scc_chan_pkg::chan_regs_t regs_b;
	scc_chan_pkg::chan_stat_t stat_a;
	scc_chan_pkg::chan_stat_t stat_b;
	logic [7:0]               data_a;
	logic [7:0]               data_b;
	logic [7:0]               wr2;
	logic [7:0]               rr2_b;
	logic [7:0]               rr3_a;

	scc_reg_access access (.clk, .reset_hw, .cen, .cs, .we, .rs, .wdata,
		.index, .wr, .resets, .data_a, .data_b);

	scc_channel chan_a (.clk, .reset_hw, .cen, .cep, .side(1'b1), .wr,
		.full_reset(resets.full), .chan_reset(resets.chan_a), .dcd(dcd_a),
		.regs(regs_a), .stat(stat_a));

	scc_channel chan_b (.clk, .reset_hw, .cen, .cep, .side(1'b0), .wr,
		.full_reset(resets.full), .chan_reset(resets.chan_b), .dcd(dcd_b),
		.regs(regs_b), .stat(stat_b));

	scc_irq_ctrl irq (.clk, .reset_hw, .cen, .wr, .stat_a, .stat_b,
		.wr2, .rr2_b, .rr3_a, .wr9(), .irq_n);

	scc_read_mux read_mux (.rs, .index, .data_a, .data_b, .wr2, .rr2_b, .rr3_a,
		.regs_a, .regs_b, .stat_a, .stat_b, .rdata);

	assign txd  = 1'b1;	// idle line.
	assign rts  = 1'b1;	// drivers off.
	assign wreq = 1'b1;	// no request.

endmodule

//--- run_sim.sh
#!/bin/sh
# compile the scc testbench with verilator, run it, then scan the log.
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module scc_tb -f build.f -o scc_sim
./obj_dir/scc_sim 2>&1 | tee sim.log
if grep -q "TB FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
